// ==== build.f ====
hdl/cache_pkg.sv
hdl/way_if.sv
hdl/sync_ram.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
testbench/cache_assertions.sv
testbench/tb_cache.sv

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    // cpu side
    input  logic                valid,
    input  logic                op,        // 1 = write
    input  index_t              index,
    input  tag_t                tag,
    input  logic [OFFSET_W-1:0] offset,
    input  strb_t               wstrb,
    input  word_t               wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,
    // memory read and refill
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  word_t               ret_data,
    // memory write-back
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output line_t               wr_data,
    input  logic                wr_rdy,
    way_if.ctrl                 way0,
    way_if.ctrl                 way1
);

    cache_state_t state, state_nx;

    // request buffer
    logic   req_op;
    index_t req_index;
    tag_t   req_tag;
    bank_t  req_bank;
    strb_t  req_wstrb;
    word_t  req_wdata;

    // write buffer
    logic   wbuf_valid;
    logic   wbuf_way;
    index_t wbuf_index;
    bank_t  wbuf_bank;
    strb_t  wbuf_wstrb;
    word_t  wbuf_wdata;

    logic [$clog2(REFILL_BEATS)-1:0] refill_cnt;
    logic [7:0] lfsr;

    logic   hit0, hit1, cache_hit;
    word_t  hit_word;
    logic   victim_way;
    tagv_t  victim_tagv;
    logic   victim_wb;
    logic   refill_done;
    word_t  store_mask;
    word_t  refill_word;
    logic   wen_way;
    index_t bank_index [NUM_BANKS];
    strb_t  bank_wen [NUM_BANKS];

    assign addr_ok = state == IDLE
                     && !(wbuf_valid && offset[OFFSET_W-1 -: BANK_W] == wbuf_bank);

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= IDLE;
        else
            state <= state_nx;
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (valid && addr_ok) state_nx = LOOKUP;
            LOOKUP:  state_nx = cache_hit ? IDLE : MISS;
            MISS:    if (!victim_wb || wr_rdy) state_nx = REPLACE;
            REPLACE: if (rd_rdy) state_nx = REFILL;
            REFILL:  if (refill_done) state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid && addr_ok) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[OFFSET_W-1 -: BANK_W];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // rdata of the rams belongs to the lookup cycle
    assign hit0      = way0.tagv_rdata.valid && way0.tagv_rdata.tag == req_tag;
    assign hit1      = way1.tagv_rdata.valid && way1.tagv_rdata.tag == req_tag;
    assign cache_hit = hit0 || hit1;
    assign hit_word  = hit1 ? way1.bank_rdata[req_bank] : way0.bank_rdata[req_bank];

    assign data_ok = (state == LOOKUP && (cache_hit || req_op))
                     || (state == REFILL && ret_valid && !req_op && refill_cnt == req_bank);
    assign rdata   = (state == LOOKUP) ? hit_word : ret_data;

    // write hit waits here one cycle before going to the bank
    always_ff @(posedge clk) begin
        if (!resetn)
            wbuf_valid <= 1'b0;
        else
            wbuf_valid <= state == LOOKUP && req_op && cache_hit;
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && req_op && cache_hit) begin
            wbuf_way   <= hit1;
            wbuf_index <= req_index;
            wbuf_bank  <= req_bank;
            wbuf_wstrb <= req_wstrb;
            wbuf_wdata <= req_wdata;
        end
    end

    // bank outputs stay on req_index from lookup onwards
    assign victim_way  = lfsr[0];
    assign victim_tagv = victim_way ? way1.tagv_rdata : way0.tagv_rdata;
    assign victim_wb   = victim_tagv.valid && (victim_way ? way1.dirty : way0.dirty);

    assign wr_req  = state == MISS && victim_wb;
    assign wr_addr = {victim_tagv.tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_way ? way1.bank_rdata : way0.bank_rdata;

    assign rd_req  = state == REPLACE;
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    assign refill_done = state == REFILL && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn)
            refill_cnt <= '0;
        else if (refill_done)
            refill_cnt <= '0;     // clear wins over the step
        else if (state == REFILL && ret_valid)
            refill_cnt <= refill_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            lfsr <= LFSR_SEED;
        else if (refill_done)
            lfsr <= {lfsr[6:0], ^(lfsr & LFSR_TAPS)};
    end

    // store merged into the refill beat of a write miss
    always_comb begin
        for (int i = 0; i < $bits(strb_t); i++)
            store_mask[8*i +: 8] = {8{req_wstrb[i]}};
    end

    assign refill_word = (req_op && refill_cnt == req_bank)
                         ? (req_wdata & store_mask) | (ret_data & ~store_mask)
                         : ret_data;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (wbuf_valid && wbuf_bank == b)
                bank_index[b] = wbuf_index;
            else
                bank_index[b] = (state == IDLE) ? index : req_index;
            if (wbuf_valid && wbuf_bank == b)
                bank_wen[b] = wbuf_wstrb;
            else if (state == REFILL && ret_valid && refill_cnt == b)
                bank_wen[b] = '1;
            else
                bank_wen[b] = '0;
        end
    end

    assign wen_way = wbuf_valid ? wbuf_way : victim_way;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign way0.bank_index[b] = bank_index[b];
        assign way1.bank_index[b] = bank_index[b];
        assign way0.bank_wen[b]   = wen_way ? '0 : bank_wen[b];
        assign way1.bank_wen[b]   = wen_way ? bank_wen[b] : '0;
    end

    assign way0.bank_wdata  = wbuf_valid ? wbuf_wdata : refill_word;
    assign way1.bank_wdata  = wbuf_valid ? wbuf_wdata : refill_word;

    assign way0.tagv_index  = (state == IDLE) ? index : req_index;
    assign way1.tagv_index  = (state == IDLE) ? index : req_index;
    assign way0.tagv_wen    = refill_done && !victim_way;
    assign way1.tagv_wen    = refill_done && victim_way;
    assign way0.tagv_wdata  = '{tag: req_tag, valid: 1'b1};
    assign way1.tagv_wdata  = '{tag: req_tag, valid: 1'b1};

    // buffered write marks dirty and refill sets dirty from the op
    assign way0.dirty_index = wbuf_valid ? wbuf_index : req_index;
    assign way1.dirty_index = wbuf_valid ? wbuf_index : req_index;
    assign way0.dirty_wen   = (wbuf_valid && !wbuf_way) || (refill_done && !victim_way);
    assign way1.dirty_wen   = (wbuf_valid && wbuf_way) || (refill_done && victim_way);
    assign way0.dirty_set   = wbuf_valid || req_op;
    assign way1.dirty_set   = wbuf_valid || req_op;

endmodule

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // geometry
    localparam int NUM_SETS     = 256;
    localparam int NUM_BANKS    = 4;    // 32-bit words per line
    localparam int TAG_W        = 20;
    localparam int INDEX_W      = 8;
    localparam int OFFSET_W     = 4;
    localparam int BANK_W       = 2;    // upper offset bits
    localparam int REFILL_BEATS = 4;

    // replacement lfsr with polynomial x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [7:0] LFSR_SEED = 8'h01;
    localparam logic [7:0] LFSR_TAPS = 8'b1011_1000;   // bits 7, 5, 4, 3

    typedef logic [31:0]          word_t;
    typedef logic [3:0]           strb_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [BANK_W-1:0]    bank_t;
    typedef logic [NUM_BANKS*32-1:0] line_t;   // bank 3 in the top word

    // tag ram entry with valid in the lsb
    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // one-hot main fsm
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } cache_state_t;

endpackage

// ==== hdl/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    // cpu request
    input  logic                valid,
    input  logic                op,
    input  index_t              index,
    input  tag_t                tag,
    input  logic [OFFSET_W-1:0] offset,
    input  strb_t               wstrb,
    input  word_t               wdata,
    // cpu response
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,
    // memory read request
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    // memory refill beats
    input  logic                ret_valid,
    input  logic                ret_last,
    input  word_t               ret_data,
    // memory write request
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output line_t               wr_data,
    input  logic                wr_rdy
);

    way_if way0_if ();
    way_if way1_if ();

    cache_way u_way0 (
        .clk    (clk),
        .resetn (resetn),
        .port   (way0_if.store)
    );

    cache_way u_way1 (
        .clk    (clk),
        .resetn (resetn),
        .port   (way1_if.store)
    );

    cache_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way0      (way0_if.ctrl),
        .way1      (way1_if.ctrl)
    );

endmodule

// ==== hdl/cache_way.sv ====
`timescale 1ns/10ps

module cache_way
    import cache_pkg::*;
(
    input logic   clk,
    input logic   resetn,
    way_if.store  port
);

    logic [NUM_SETS-1:0] dirty_q;

    // four byte-writable word banks
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sync_ram #(
            .entry_t    (word_t),
            .BYTE_WRITE (1'b1)
        ) u_bank (
            .clk    (clk),
            .resetn (resetn),
            .index  (port.bank_index[b]),
            .wen    (port.bank_wen[b]),
            .wdata  (port.bank_wdata),
            .rdata  (port.bank_rdata[b])
        );
    end

    // tag and valid are written as a whole entry
    sync_ram #(
        .entry_t    (tagv_t),
        .BYTE_WRITE (1'b0)
    ) u_tagv (
        .clk    (clk),
        .resetn (resetn),
        .index  (port.tagv_index),
        .wen    ({4{port.tagv_wen}}),
        .wdata  (port.tagv_wdata),
        .rdata  (port.tagv_rdata)
    );

    // flop based dirty bits so the victim check needs no extra cycle
    always_ff @(posedge clk) begin
        if (!resetn)
            dirty_q <= '0;
        else if (port.dirty_wen)
            dirty_q[port.dirty_index] <= port.dirty_set;
    end

    assign port.dirty = dirty_q[port.dirty_index];

endmodule

// ==== hdl/sync_ram.sv ====
`timescale 1ns/10ps

module sync_ram
    import cache_pkg::*;
#(
    parameter type entry_t    = word_t,
    parameter bit  BYTE_WRITE = 1'b1
) (
    input  logic   clk,
    input  logic   resetn,
    input  index_t index,
    input  strb_t  wen,
    input  entry_t wdata,
    output entry_t rdata
);

    entry_t mem [NUM_SETS];

    if (BYTE_WRITE) begin : g_byte
        // data bank with one enable per byte lane
        always_ff @(posedge clk) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wen[b])
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end else begin : g_whole
        // tag/valid store is cleared so every line starts invalid
        always_ff @(posedge clk) begin
            if (!resetn) begin
                for (int i = 0; i < NUM_SETS; i++)
                    mem[i] <= '0;
            end else if (|wen) begin
                mem[index] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            rdata <= '0;
        else
            rdata <= mem[index];   // old data on a same-cycle write
    end

endmodule

// ==== hdl/way_if.sv ====
`timescale 1ns/10ps

// ports of one way between the controller and the way store
interface way_if
    import cache_pkg::*;
();

    index_t [NUM_BANKS-1:0] bank_index;   // each bank has its own index
    strb_t  [NUM_BANKS-1:0] bank_wen;
    word_t                  bank_wdata;   // shared by all banks
    word_t  [NUM_BANKS-1:0] bank_rdata;

    index_t tagv_index;
    logic   tagv_wen;
    tagv_t  tagv_wdata;
    tagv_t  tagv_rdata;

    index_t dirty_index;
    logic   dirty_wen;
    logic   dirty_set;
    logic   dirty;                        // combinational at dirty_index

    modport ctrl (
        output bank_index, bank_wen, bank_wdata,
        output tagv_index, tagv_wen, tagv_wdata,
        output dirty_index, dirty_wen, dirty_set,
        input  bank_rdata, tagv_rdata, dirty
    );

    modport store (
        input  bank_index, bank_wen, bank_wdata,
        input  tagv_index, tagv_wen, tagv_wdata,
        input  dirty_index, dirty_wen, dirty_set,
        output bank_rdata, tagv_rdata, dirty
    );

endinterface

// ==== testbench/cache_assertions.sv ====
`timescale 1ns/10ps

module cache_assertions
    import cache_pkg::*;
(
    input logic         clk,
    input logic         resetn,
    input logic         valid,
    input logic         addr_ok,
    input logic         data_ok,
    input logic         rd_req,
    input logic         rd_rdy,
    input logic         ret_valid,
    input logic         wr_req,
    input logic         wr_rdy,
    input logic [31:0]  wr_addr,
    input line_t        wr_data
);

    logic pending;   // taken and data_ok still to come

    always_ff @(posedge clk) begin
        if (!resetn)
            pending <= 1'b0;
        else if (valid && addr_ok)
            pending <= 1'b1;
        else if (data_ok)
            pending <= 1'b0;
    end

    // memory requests stay up until taken
    rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    wr_payload_stable: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> $stable(wr_addr) && $stable(wr_data))
        else $error("wr_addr or wr_data changed while wr_req waits");

    // a response needs a request in flight
    data_ok_in_flight: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> pending)
        else $error("data_ok with no outstanding request");

    addr_ok_busy: assert property (@(posedge clk) disable iff (!resetn)
        pending || rd_req || wr_req || ret_valid |-> !addr_ok)
        else $error("addr_ok high while a request is in flight");

endmodule

bind cache_ctrl cache_assertions u_assertions (.*);

// ==== testbench/tb_cache.sv ====
`timescale 1ns/10ps

module tb_cache
    import cache_pkg::*;
();

    localparam int          NUM_TESTS  = 15;
    localparam int          MAX_CYCLES = NUM_TESTS * 60 + 100;
    localparam logic [31:0] RAND_SEED  = 32'h4860;
    localparam int          MEM_WORDS  = 8192;   // tags 0..7 only

    typedef struct packed {
        logic  op;      // 1 = write
        logic [31:0] addr;
        strb_t strb;
        word_t data;
        logic  hit;     // expected lookup result
    } stim_t;

    // set 0x10 sees four tags and set 0x20 takes the rest
    stim_t tests [NUM_TESTS] = '{
        '{1'b0, 32'h0000_1104, 4'h0, 32'h0000_0000, 1'b0},
        '{1'b0, 32'h0000_1104, 4'h0, 32'h0000_0000, 1'b1},
        '{1'b1, 32'h0000_1108, 4'h3, 32'hDEAD_BEEF, 1'b1},
        '{1'b0, 32'h0000_1108, 4'h0, 32'h0000_0000, 1'b1},   // same bank right after
        '{1'b1, 32'h0000_2100, 4'hC, 32'h1234_5678, 1'b0},
        '{1'b0, 32'h0000_2100, 4'h0, 32'h0000_0000, 1'b1},
        '{1'b0, 32'h0000_310C, 4'h0, 32'h0000_0000, 1'b0},   // evicts dirty tag 2
        '{1'b0, 32'h0000_2100, 4'h0, 32'h0000_0000, 1'b0},
        '{1'b1, 32'h0000_5204, 4'hF, 32'hCAFE_F00D, 1'b0},
        '{1'b0, 32'h0000_1108, 4'h0, 32'h0000_0000, 1'b1},
        '{1'b0, 32'h0000_4100, 4'h0, 32'h0000_0000, 1'b0},   // evicts dirty tag 1
        '{1'b0, 32'h0000_1108, 4'h0, 32'h0000_0000, 1'b0},
        '{1'b1, 32'h0000_5204, 4'h4, 32'h0055_0000, 1'b1},
        '{1'b0, 32'h0000_5204, 4'h0, 32'h0000_0000, 1'b1},
        '{1'b0, 32'h0000_620C, 4'h0, 32'h0000_0000, 1'b0}
    };

    logic clk = 1'b0;
    logic resetn, valid, op, addr_ok, data_ok;
    index_t index;
    tag_t tag;
    logic [OFFSET_W-1:0] offset;
    strb_t wstrb;
    word_t wdata, rdata, ret_data;
    logic rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [31:0] rd_addr, wr_addr;
    line_t wr_data;

    logic [31:0] seed;
    word_t mem [MEM_WORDS];       // memory behind the cache
    word_t exp_mem [MEM_WORDS];   // what a cpu read should return
    tag_t m_tag [NUM_SETS][2];
    logic m_valid [NUM_SETS][2];
    logic m_dirty [NUM_SETS][2];
    logic [7:0] m_lfsr;
    int errors, checks, cycles;
    logic rd_seen, wr_seen;
    logic [31:0] seen_rd_addr, seen_wr_addr;
    line_t seen_wr_data;

    cache_top cache_top_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 16;
    endfunction

    function automatic word_t fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h3C5A_96E1;
    endfunction

    task automatic compare(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // memory side with random ready and beat delays
    always begin
        @(posedge clk);
        if (resetn && wr_req) begin
            wr_seen = 1'b1;
            seen_wr_addr = wr_addr;
            seen_wr_data = wr_data;
            repeat (1 + next_rand() % 4) @(negedge clk);
            wr_rdy = 1'b1;
            @(negedge clk);
            wr_rdy = 1'b0;
            for (int b = 0; b < NUM_BANKS; b++)
                mem[{seen_wr_addr[14:4], 2'(b)}] = seen_wr_data[32*b +: 32];
        end else if (resetn && rd_req) begin
            rd_seen = 1'b1;
            seen_rd_addr = rd_addr;
            repeat (1 + next_rand() % 4) @(negedge clk);
            rd_rdy = 1'b1;
            @(negedge clk);
            rd_rdy = 1'b0;
            for (int b = 0; b < REFILL_BEATS; b++) begin
                repeat (next_rand() % 3) @(negedge clk);   // gap between beats
                ret_valid = 1'b1;
                ret_data = mem[{seen_rd_addr[14:4], 2'(b)}];
                ret_last = b == REFILL_BEATS - 1;
                @(negedge clk);
                ret_valid = 1'b0;
                ret_last = 1'b0;
            end
        end
    end

    // reference cache picking its victim by lfsr bit 0
    task automatic model_access(input stim_t s, output logic hit, output logic wb,
                                output logic [31:0] wb_addr, output line_t wb_line);
        index_t idx;
        tag_t tg;
        int way;
        idx = s.addr[11:4];
        tg = s.addr[31:12];
        way = -1;
        for (int w = 0; w < 2; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == tg)
                way = w;
        hit = way >= 0;
        wb = 1'b0;
        if (!hit) begin
            way = m_lfsr[0];
            wb = m_valid[idx][way] && m_dirty[idx][way];
            wb_addr = {m_tag[idx][way], idx, 4'h0};
            for (int b = 0; b < NUM_BANKS; b++)
                wb_line[32*b +: 32] = exp_mem[{wb_addr[14:4], 2'(b)}];
            m_tag[idx][way] = tg;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = s.op;
            m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5] ^ m_lfsr[4] ^ m_lfsr[3]};
        end else if (s.op) begin
            m_dirty[idx][way] = 1'b1;
        end
        for (int i = 0; i < 4; i++)
            if (s.op && s.strb[i])
                exp_mem[s.addr[14:2]][8*i +: 8] = s.data[8*i +: 8];
    endtask

    task automatic run_test(input int n);
        stim_t s;
        logic hit, wb;
        logic [31:0] wb_addr;
        line_t wb_line;
        word_t got;
        int errs_before;
        s = tests[n];
        errs_before = errors;
        model_access(s, hit, wb, wb_addr, wb_line);
        if (hit !== s.hit) begin
            errors++;
            $display("test %0d: reference model and table disagree on hit or miss", n);
        end
        @(negedge clk);
        valid = 1'b1;
        op = s.op;
        tag = s.addr[31:12];
        index = s.addr[11:4];
        offset = s.addr[3:0];
        wstrb = s.strb;
        wdata = s.data;
        do @(posedge clk); while (!addr_ok);
        if (rd_seen || wr_seen) begin
            errors++;
            $display("test %0d: memory request seen before the request was taken", n);
        end
        @(negedge clk);
        valid = 1'b0;
        do @(posedge clk); while (!data_ok);
        got = rdata;
        if (!hit)
            do @(posedge clk); while (!addr_ok);   // let refill finish
        compare("rd_req", rd_seen, !hit);
        if (!hit)
            compare("rd_addr", seen_rd_addr, {s.addr[31:4], 4'h0});
        compare("wr_req", wr_seen, wb);
        if (wb) begin
            compare("wr_addr", seen_wr_addr, wb_addr);
            compare("wr_data", seen_wr_data, wb_line);
        end
        if (!s.op)
            compare("rdata", got, exp_mem[s.addr[14:2]]);
        rd_seen = 1'b0;
        wr_seen = 1'b0;
        $display("test %0d: %s %h %s %s", n, s.op ? "write" : "read ", s.addr,
                 hit ? "hit " : "miss", errors == errs_before ? "ok" : "FAIL");
    endtask

    initial begin
        seed = RAND_SEED;
        {resetn, valid, op, index, tag, offset, wstrb, wdata} = '0;
        {rd_rdy, ret_valid, ret_last, ret_data, wr_rdy} = '0;
        {errors, checks, cycles} = '0;
        {rd_seen, wr_seen} = '0;
        m_lfsr = LFSR_SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word({17'd0, 13'(i), 2'd0});
            exp_mem[i] = mem[i];
        end
        for (int i = 0; i < NUM_SETS; i++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[i][w] = '0;
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(posedge clk);
        compare("addr_ok", addr_ok, 1'b1);
        compare("data_ok", data_ok, 1'b0);
        compare("rd_req", rd_req, 1'b0);
        compare("wr_req", wr_req, 1'b0);
        $display("test reset: %s", errors == 0 ? "ok" : "FAIL");
        for (int n = 0; n < NUM_TESTS; n++)
            run_test(n);
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
